/* verilog.f */
+incdir+tb
hw/mem_stage_pkg.sv
hw/mem_stage_reg.sv
hw/store_align.sv
hw/ram_lane.sv
hw/load_extract.sv
hw/writeback_select.sv
hw/mem_stage_top.sv
tb/mem_stage_tb.sv

/* Makefile */
# Verilator build and run of the memory-stage testbench

SIM      = verilator
TOP      = mem_stage_tb
FILELIST = verilog.f
BUILD    = obj_dir
FLAGS    = --binary --timing --top-module $(TOP) -Mdir $(BUILD)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

# a failing check ends in \$$fatal, so the run returns a nonzero status
test:
	$(SIM) $(FLAGS) -f $(FILELIST)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)

/* tb/mem_stage_ref.svh */
`ifndef mem_stage_ref_svh
`define mem_stage_ref_svh

// byte image of the data memory, index = word * 8 + byte offset
logic [7:0] model_mem [mem_words*lanes];

// ends the run after an error line
task automatic stop_run();
    $display("Result: FAILED");
    $fatal(1, "simulation stopped at the first error");
endtask

task automatic check_wen(input string name, input logic got, input logic want);
    if (got !== want) begin
        $display("** Error at %0t ns: %s got %h expected %h", $time, name, got, want);
        stop_run();
    end
endtask

task automatic check_id(input string name, input logic [4:0] got, input logic [4:0] want);
    if (got !== want) begin
        $display("** Error at %0t ns: %s got %h expected %h", $time, name, got, want);
        stop_run();
    end
endtask

task automatic check_value(input string name, input logic [xlen-1:0] got,
                           input logic [xlen-1:0] want);
    if (got !== want) begin
        $display("** Error at %0t ns: %s got %h expected %h", $time, name, got, want);
        stop_run();
    end
endtask

task automatic check_pc(input string name, input logic [xlen-1:0] got,
                        input logic [xlen-1:0] want);
    if (got !== want) begin
        $display("** Error at %0t ns: %s got %h expected %h", $time, name, got, want);
        stop_run();
    end
endtask

task automatic check_inst(input string name, input logic [inst_width-1:0] got,
                          input logic [inst_width-1:0] want);
    if (got !== want) begin
        $display("** Error at %0t ns: %s got %h expected %h", $time, name, got, want);
        stop_run();
    end
endtask

// **********************************************************************
// expected write-back for one accepted item
// **********************************************************************

function automatic void ref_model(input logic [op_width-1:0] op, input logic [xlen-1:0] pc,
                                  input logic [inst_width-1:0] inst,
                                  input logic [xlen-1:0] alu, input logic [xlen-1:0] src2);
    int              base;
    int              off;
    logic [xlen-1:0] word;
    logic [15:0]     half;
    logic [31:0]     wrd;
    logic            wen;
    logic [xlen-1:0] value;
    base = int'((alu >> 3) % mem_words) * lanes;
    off  = int'(alu[2:0]);
    for (int i = 0; i < lanes; i++) begin
        word[i*8 +: 8] = model_mem[base + i];
    end
    // half at byte 7 would leave the word, reads as zero
    half  = (off == 7) ? 16'h0 : {model_mem[base + (off + 1) % lanes], model_mem[base + off]};
    wrd   = (off >= 4) ? word[63:32] : word[31:0];
    wen   = 1'b1;
    value = '0;
    case (op)
        op_jal, op_jalr:    value = pc + 64'd4;
        op_csrrw, op_csrrs: value = src2;
        op_lb:  value = {{56{word[off*8+7]}}, word[off*8 +: 8]};
        op_lbu: value = {56'h0, word[off*8 +: 8]};
        op_lh:  value = {{48{half[15]}}, half};
        op_lhu: value = {48'h0, half};
        op_lw:  value = {{32{wrd[31]}}, wrd};
        op_lwu: value = {32'h0, wrd};
        op_ld:  value = word;
        op_sb, op_sh, op_sw, op_sd: begin
            // stores write no register
            wen = 1'b0;
            for (int i = 0; i < lanes; i++) begin
                if ((op == op_sb && i == off) || op == op_sd ||
                    (op == op_sh && off != 7 && (i == off || i == off + 1)) ||
                    (op == op_sw && i / 4 == off / 4)) begin
                    model_mem[base + i] = src2[(i - (op == op_sd ? 0 :
                        op == op_sw ? (off & 4) : off))*8 +: 8];
                end
            end
        end
        default: begin
            // alu class by table, anything else unknown
            wen = 1'b0;
            for (int i = 0; i < alu_wb_count; i++) begin
                if (op == alu_wb_ops[i]) begin
                    wen = 1'b1;
                end
            end
            value = wen ? alu : '0;
        end
    endcase
    exp_wen_q.push_back(wen);
    exp_id_q.push_back(inst[11:7]);
    exp_value_q.push_back(value);
    exp_pc_q.push_back(pc);
    exp_inst_q.push_back(inst);
endfunction

`endif

/* tb/mem_stage_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_stage_tb
    import mem_stage_pkg::*;
();

    localparam int mem_words   = 256;
    localparam int cycle_ns    = 8;
    localparam int reg_items   = 48;
    localparam int mem_rounds  = 3;
    // per round: init, store, seven loads
    localparam int mem_items   = 4 * mem_rounds * 9;
    localparam int edge_items  = 5;
    localparam int stall_items = 60;
    localparam int num_items   = reg_items + mem_items + edge_items + stall_items + 4;
    // eight cycles per item covers the longest stall, plus reset and drain
    localparam int timeout_ns  = (num_items * 8 + 40) * cycle_ns;
    localparam logic [op_width-1:0] unknown_op = 24'h0abcde;
    localparam logic [op_width-1:0] store_ops [4] = '{op_sb, op_sh, op_sw, op_sd};
    localparam logic [op_width-1:0] load_ops [7] =
        '{op_lb, op_lh, op_lw, op_lbu, op_lhu, op_lwu, op_ld};

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  valid_ex_mem;
    logic                  ready_ex_mem;
    logic [xlen-1:0]       pc_ex_mem;
    logic [inst_width-1:0] inst_ex_mem;
    logic [op_width-1:0]   opcode_in;
    logic [xlen-1:0]       alu_result_in;
    logic [xlen-1:0]       src2_in;
    logic                  valid_mem_wb;
    logic                  ready_mem_wb;
    logic [xlen-1:0]       pc_mem_wb;
    logic [inst_width-1:0] inst_mem_wb;
    logic                  reg_wr_wen;
    logic [4:0]            reg_wr_id;
    logic [xlen-1:0]       reg_wr_value;

    // expected write-back, one entry per valid item
    logic                  exp_wen_q [$];
    logic [4:0]            exp_id_q [$];
    logic [xlen-1:0]       exp_value_q [$];
    logic [xlen-1:0]       exp_pc_q [$];
    logic [inst_width-1:0] exp_inst_q [$];
    bit                    stall_mode;
    // output snapshot for the stall hold check
    bit                    held;
    logic                  last_valid;
    logic                  last_wen;
    logic [4:0]            last_id;
    logic [xlen-1:0]       last_value;
    logic [xlen-1:0]       last_pc;
    logic [inst_width-1:0] last_inst;

    `include "mem_stage_ref.svh"

    mem_stage_top #(.mem_words(mem_words)) u_mem_stage_top (
        .clk           (clk),
        .rst           (rst),
        .valid_ex_mem  (valid_ex_mem),
        .ready_ex_mem  (ready_ex_mem),
        .pc_ex_mem     (pc_ex_mem),
        .inst_ex_mem   (inst_ex_mem),
        .opcode_in     (opcode_in),
        .alu_result_in (alu_result_in),
        .src2_in       (src2_in),
        .valid_mem_wb  (valid_mem_wb),
        .ready_mem_wb  (ready_mem_wb),
        .pc_mem_wb     (pc_mem_wb),
        .inst_mem_wb   (inst_mem_wb),
        .reg_wr_wen    (reg_wr_wen),
        .reg_wr_id     (reg_wr_id),
        .reg_wr_value  (reg_wr_value)
    );

    initial begin
        forever #(cycle_ns / 2) clk = ~clk;
    end

    initial begin
        #(timeout_ns);
        $display("timeout: run still busy after %0d ns", timeout_ns);
        stop_run();
    end

    function automatic logic [xlen-1:0] rand64();
        return {$urandom(), $urandom()};
    endfunction

    // random upper bits exercise the wrap at mem_words
    function automatic logic [xlen-1:0] make_addr(input int word, input int off);
        logic [xlen-1:0] upper;
        upper = 64'($urandom()) << (lane_bits + $clog2(mem_words));
        return upper | (64'(word) << lane_bits) | 64'(off);
    endfunction

    // offer one item, optionally stall first, model it at its capture edge
    task automatic drive_item(input logic v, input logic [op_width-1:0] op,
                              input logic [xlen-1:0] alu, input logic [xlen-1:0] src2);
        logic [xlen-1:0]       pc;
        logic [inst_width-1:0] inst;
        pc            = rand64() & ~64'h3;
        inst          = $urandom();
        valid_ex_mem  = v;
        pc_ex_mem     = pc;
        inst_ex_mem   = inst;
        opcode_in     = op;
        alu_result_in = alu;
        src2_in       = src2;
        if (stall_mode && $urandom_range(0, 2) == 0) begin
            ready_mem_wb = 1'b0;
            repeat ($urandom_range(1, 4)) @(posedge clk);
            #1;
        end
        ready_mem_wb = 1'b1;
        @(posedge clk);
        if (v) begin
            ref_model(op, pc, inst, alu, src2);
        end
        #1;
    endtask

    // **********************************************************************
    // compare at the falling edge, away from all input and output changes
    // **********************************************************************

    always @(negedge clk) begin
        check_wen("ready_ex_mem", ready_ex_mem, ready_mem_wb);
        if (held) begin
            check_wen("valid_mem_wb", valid_mem_wb, last_valid);
            check_wen("reg_wr_wen", reg_wr_wen, last_wen);
            check_id("reg_wr_id", reg_wr_id, last_id);
            check_value("reg_wr_value", reg_wr_value, last_value);
            check_pc("pc_mem_wb", pc_mem_wb, last_pc);
            check_inst("inst_mem_wb", inst_mem_wb, last_inst);
        end
        if (rst) begin
            check_wen("valid_mem_wb", valid_mem_wb, 1'b0);
            check_wen("reg_wr_wen", reg_wr_wen, 1'b0);
        end else if (!valid_mem_wb) begin
            // bubble, nothing to write back
            check_wen("reg_wr_wen", reg_wr_wen, 1'b0);
            check_id("reg_wr_id", reg_wr_id, 5'd0);
            check_value("reg_wr_value", reg_wr_value, '0);
            check_pc("pc_mem_wb", pc_mem_wb, '0);
            check_inst("inst_mem_wb", inst_mem_wb, '0);
        end else if (ready_mem_wb) begin
            if (exp_wen_q.size() == 0) begin
                $display("valid_mem_wb high at %0t ns with no item outstanding", $time);
                stop_run();
            end else begin
                check_wen("reg_wr_wen", reg_wr_wen, exp_wen_q.pop_front());
                check_id("reg_wr_id", reg_wr_id, exp_id_q.pop_front());
                check_value("reg_wr_value", reg_wr_value, exp_value_q.pop_front());
                check_pc("pc_mem_wb", pc_mem_wb, exp_pc_q.pop_front());
                check_inst("inst_mem_wb", inst_mem_wb, exp_inst_q.pop_front());
            end
        end
        held       = !ready_mem_wb;
        last_valid = valid_mem_wb;
        last_wen   = reg_wr_wen;
        last_id    = reg_wr_id;
        last_value = reg_wr_value;
        last_pc    = pc_mem_wb;
        last_inst  = inst_mem_wb;
    end

    // **********************************************************************
    // stimulus
    // **********************************************************************

    initial begin
        int                  word;
        logic [op_width-1:0] op;
        void'($urandom(77));
        rst           = 1'b1;
        valid_ex_mem  = 1'b0;
        ready_mem_wb  = 1'b1;
        pc_ex_mem     = '0;
        inst_ex_mem   = '0;
        opcode_in     = '0;
        alu_result_in = '0;
        src2_in       = '0;
        stall_mode    = 1'b0;
        held          = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        drive_item(1'b0, '0, '0, '0);

        // alu class, link, csr and unknown opcodes
        for (int n = 0; n < reg_items; n++) begin
            case ($urandom_range(0, 3))
                0: op = alu_wb_ops[$urandom_range(0, alu_wb_count - 1)];
                1: op = $urandom_range(0, 1) ? op_jal : op_jalr;
                2: op = $urandom_range(0, 1) ? op_csrrw : op_csrrs;
                default: op = unknown_op;
            endcase
            drive_item(1'b1, op, rand64(), rand64());
        end

        // every store width, then every load back to back
        for (int s = 0; s < 4; s++) begin
            for (int r = 0; r < mem_rounds; r++) begin
                word = $urandom_range(0, mem_words - 1);
                drive_item(1'b1, op_sd, make_addr(word, 0), rand64());
                drive_item(1'b1, store_ops[s], make_addr(word, $urandom_range(0, 7)), rand64());
                for (int l = 0; l < 7; l++) begin
                    drive_item(1'b1, load_ops[l], make_addr(word, $urandom_range(0, 7)), rand64());
                end
            end
        end

        // half access at byte 7
        word = $urandom_range(0, mem_words - 1);
        drive_item(1'b1, op_sd, make_addr(word, 0), rand64());
        drive_item(1'b1, op_sh, make_addr(word, 7), rand64());
        drive_item(1'b1, op_ld, make_addr(word, 0), rand64());
        drive_item(1'b1, op_lh, make_addr(word, 7), rand64());
        drive_item(1'b1, op_lhu, make_addr(word, 7), rand64());

        // store offered under stall, then withdrawn before capture
        stall_mode = 1'b1;
        word = $urandom_range(0, mem_words - 1);
        drive_item(1'b1, op_sd, make_addr(word, 0), rand64());
        ready_mem_wb  = 1'b0;
        valid_ex_mem  = 1'b1;
        opcode_in     = op_sd;
        alu_result_in = make_addr(word, 0);
        src2_in       = rand64();
        repeat (3) @(posedge clk);
        #1;
        drive_item(1'b1, op_ld, make_addr(word, 0), rand64());

        // mixed traffic with bubbles and random back-pressure
        for (int n = 0; n < stall_items; n++) begin
            case ($urandom_range(0, 3))
                0: drive_item(1'b0, '0, '0, '0);
                1: drive_item(1'b1, store_ops[$urandom_range(0, 3)],
                              make_addr(word, $urandom_range(0, 7)), rand64());
                2: drive_item(1'b1, alu_wb_ops[$urandom_range(0, alu_wb_count - 1)],
                              rand64(), rand64());
                default: drive_item(1'b1, load_ops[$urandom_range(0, 6)],
                                    make_addr(word, $urandom_range(0, 7)), rand64());
            endcase
        end

        // drain
        stall_mode = 1'b0;
        drive_item(1'b0, '0, '0, '0);
        for (int i = 0; i < 20 && exp_wen_q.size() != 0; i++) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        if (exp_wen_q.size() == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            $display("%0d expected items never reached write-back", exp_wen_q.size());
            stop_run();
        end
    end

endmodule

`default_nettype wire

/* hw/mem_stage_top.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_stage_top
    import mem_stage_pkg::*;
#(
    parameter int mem_words = 256
) (
    input  wire logic                  clk,
    input  wire logic                  rst,
    // execute side
    input  wire logic                  valid_ex_mem,
    output logic                       ready_ex_mem,
    input  wire logic [xlen-1:0]       pc_ex_mem,
    input  wire logic [inst_width-1:0] inst_ex_mem,
    input  wire logic [op_width-1:0]   opcode_in,
    input  wire logic [xlen-1:0]       alu_result_in,
    input  wire logic [xlen-1:0]       src2_in,
    // write-back side
    output logic                       valid_mem_wb,
    input  wire logic                  ready_mem_wb,
    output logic [xlen-1:0]            pc_mem_wb,
    output logic [inst_width-1:0]      inst_mem_wb,
    output logic                       reg_wr_wen,
    output logic [4:0]                 reg_wr_id,
    output logic [xlen-1:0]            reg_wr_value
);

    localparam int index_width = $clog2(mem_words);

    logic                   capture;
    logic                   stage_valid;
    logic [xlen-1:0]        stage_pc;
    logic [inst_width-1:0]  stage_inst;
    logic [op_width-1:0]    stage_opcode;
    logic [xlen-1:0]        stage_alu_result;
    logic [xlen-1:0]        stage_src2;
    logic [lanes-1:0]       lane_we;
    logic [lanes*8-1:0]     lane_wdata;
    logic [lanes*8-1:0]     lane_rdata;
    logic [index_width-1:0] word_index;
    logic [xlen-1:0]        load_value;

    // no internal stall, ready straight through
    assign capture      = ready_mem_wb;
    assign ready_ex_mem = ready_mem_wb;

    mem_stage_reg u_mem_stage_reg (
        .clk           (clk),
        .rst           (rst),
        .capture       (capture),
        .valid_in      (valid_ex_mem),
        .pc_in         (pc_ex_mem),
        .inst_in       (inst_ex_mem),
        .opcode_in     (opcode_in),
        .alu_result_in (alu_result_in),
        .src2_in       (src2_in),
        .valid         (stage_valid),
        .pc            (stage_pc),
        .inst          (stage_inst),
        .opcode        (stage_opcode),
        .alu_result    (stage_alu_result),
        .src2          (stage_src2)
    );

    // **********************************************************************
    // data memory, accessed at the capture edge
    // **********************************************************************

    store_align #(.mem_words(mem_words)) u_store_align (
        .capture    (capture),
        .valid_in   (valid_ex_mem),
        .opcode_in  (opcode_in),
        .addr_in    (alu_result_in),
        .src2_in    (src2_in),
        .lane_we    (lane_we),
        .lane_wdata (lane_wdata),
        .word_index (word_index)
    );

    for (genvar i = 0; i < lanes; i++) begin : g_lane
        ram_lane #(.mem_words(mem_words)) u_ram_lane (
            .clk   (clk),
            .en    (capture),
            .we    (lane_we[i]),
            .index (word_index),
            .wdata (lane_wdata[i*8 +: 8]),
            .rdata (lane_rdata[i*8 +: 8])
        );
    end

    // registered opcode and offset line up with the lane read
    load_extract u_load_extract (
        .opcode      (stage_opcode),
        .byte_offset (stage_alu_result[lane_bits-1:0]),
        .lane_rdata  (lane_rdata),
        .load_value  (load_value)
    );

    writeback_select u_writeback_select (
        .valid        (stage_valid),
        .pc           (stage_pc),
        .inst         (stage_inst),
        .opcode       (stage_opcode),
        .alu_result   (stage_alu_result),
        .src2         (stage_src2),
        .load_value   (load_value),
        .reg_wr_wen   (reg_wr_wen),
        .reg_wr_id    (reg_wr_id),
        .reg_wr_value (reg_wr_value)
    );

    // stage contents to write-back, zero on a bubble
    assign valid_mem_wb = stage_valid;
    assign pc_mem_wb    = stage_valid ? stage_pc : '0;
    assign inst_mem_wb  = stage_valid ? stage_inst : '0;

endmodule

`default_nettype wire

/* hw/writeback_select.sv */
`timescale 1ns/1ns
`default_nettype none

module writeback_select
    import mem_stage_pkg::*;
(
    input  wire logic                  valid,
    input  wire logic [xlen-1:0]       pc,
    input  wire logic [inst_width-1:0] inst,
    input  wire logic [op_width-1:0]   opcode,
    input  wire logic [xlen-1:0]       alu_result,
    input  wire logic [xlen-1:0]       src2,
    input  wire logic [xlen-1:0]       load_value,
    output logic                       reg_wr_wen,
    output logic [4:0]                 reg_wr_id,
    output logic [xlen-1:0]            reg_wr_value
);

    logic       writes;
    logic [1:0] src;
    logic [xlen-1:0] value;

    // decode rd write and its source
    always_comb begin
        writes = wb_source_of(opcode, src);
        case (src)
            wb_link: value = pc + xlen'(4);
            wb_load: value = load_value;
            wb_src2: value = src2;
            default: value = alu_result;
        endcase
    end

    // **********************************************************************
    // gate with stage valid
    // **********************************************************************

    assign reg_wr_wen   = valid && writes;
    // unknown opcode gives zero value
    assign reg_wr_value = reg_wr_wen ? value : '0;
    assign reg_wr_id    = valid ? inst[11:7] : 5'd0;

endmodule

`default_nettype wire

/* hw/load_extract.sv */
`timescale 1ns/1ns
`default_nettype none

module load_extract
    import mem_stage_pkg::*;
(
    input  wire logic [op_width-1:0]  opcode,
    input  wire logic [lane_bits-1:0] byte_offset,
    input  wire logic [lanes*8-1:0]   lane_rdata,
    output logic [xlen-1:0]           load_value
);

    mem_word_t            word;
    logic [lane_bits-1:0] next_offset;
    logic [7:0]           byte_val;
    logic [15:0]          half_val;
    logic [31:0]          word_val;

    // lanes packed back into one word
    assign word        = mem_word_t'(lane_rdata);
    assign next_offset = byte_offset + lane_bits'(1);

    // **********************************************************************
    // pick the addressed part
    // **********************************************************************

    always_comb begin
        byte_val = word.bytes[byte_offset];
        // half at the last byte would wrap, gives zero
        if (byte_offset == '1) begin
            half_val = '0;
        end else begin
            half_val = {word.bytes[next_offset], word.bytes[byte_offset]};
        end
        // word half by offset bit 2
        word_val = word.halves[byte_offset[lane_bits-1]];
    end

    // sign or zero extension
    always_comb begin
        case (opcode)
            op_lb:   load_value = {{(xlen-8){byte_val[7]}}, byte_val};
            op_lh:   load_value = {{(xlen-16){half_val[15]}}, half_val};
            op_lw:   load_value = {{(xlen-32){word_val[31]}}, word_val};
            op_lbu:  load_value = {{(xlen-8){1'b0}}, byte_val};
            op_lhu:  load_value = {{(xlen-16){1'b0}}, half_val};
            op_lwu:  load_value = {{(xlen-32){1'b0}}, word_val};
            op_ld:   load_value = word;
            // not a load
            default: load_value = '0;
        endcase
    end

endmodule

`default_nettype wire

/* hw/ram_lane.sv */
`timescale 1ns/1ns
`default_nettype none

module ram_lane #(
    parameter int mem_words = 256
) (
    input  wire logic                         clk,
    input  wire logic                         en,
    input  wire logic                         we,
    input  wire logic [$clog2(mem_words)-1:0] index,
    input  wire logic [7:0]                   wdata,
    output logic [7:0]                        rdata
);

    localparam int index_width = $clog2(mem_words);

    // one byte per word of the data memory
    logic [7:0] mem [2**index_width];

    // read-before-write, read register holds while en is low
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[index] <= wdata;
            end
            rdata <= mem[index];
        end
    end

endmodule

`default_nettype wire

/* hw/store_align.sv */
`timescale 1ns/1ns
`default_nettype none

module store_align
    import mem_stage_pkg::*;
#(
    parameter int mem_words = 256
) (
    input  wire logic                         capture,
    input  wire logic                         valid_in,
    input  wire logic [op_width-1:0]          opcode_in,
    input  wire logic [xlen-1:0]              addr_in,
    input  wire logic [xlen-1:0]              src2_in,
    output logic [lanes-1:0]                  lane_we,
    output logic [lanes*8-1:0]                lane_wdata,
    output logic [$clog2(mem_words)-1:0]      word_index
);

    localparam int index_width = $clog2(mem_words);

    logic [lane_bits-1:0] offset;
    logic [lanes-1:0]     mask;
    // shift in bits, byte offset times 8
    logic [lane_bits+2:0] shamt;
    logic                 upper_half;

    assign offset     = addr_in[lane_bits-1:0];
    assign upper_half = offset[lane_bits-1];

    // word address, wraps at mem_words
    assign word_index = addr_in[lane_bits +: index_width];

    // **********************************************************************
    // lane mask and data shift per store width
    // **********************************************************************

    always_comb begin
        mask  = '0;
        shamt = '0;
        case (opcode_in)
            op_sb: begin
                mask  = lanes'(1) << offset;
                shamt = {offset, 3'b000};
            end
            op_sh: begin
                // half crossing the word edge writes nothing
                if (offset != '1) begin
                    mask  = lanes'(3) << offset;
                    shamt = {offset, 3'b000};
                end
            end
            op_sw: begin
                // word goes to low or high half, low offset bits ignored
                mask  = {{(lanes/2){upper_half}}, {(lanes/2){~upper_half}}};
                shamt = {upper_half, {(lane_bits-1){1'b0}}, 3'b000};
            end
            op_sd: begin
                mask = '1;
            end
            default: begin
                mask = '0;
            end
        endcase
    end

    // only a real store at a capture edge touches the lanes
    assign lane_we = (capture && valid_in) ? mask : '0;

    // low operand bytes moved up to their lanes
    assign lane_wdata = src2_in << shamt;

endmodule

`default_nettype wire

/* hw/mem_stage_reg.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_stage_reg
    import mem_stage_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  capture,
    input  wire logic                  valid_in,
    input  wire logic [xlen-1:0]       pc_in,
    input  wire logic [inst_width-1:0] inst_in,
    input  wire logic [op_width-1:0]   opcode_in,
    input  wire logic [xlen-1:0]       alu_result_in,
    input  wire logic [xlen-1:0]       src2_in,
    output logic                       valid,
    output logic [xlen-1:0]            pc,
    output logic [inst_width-1:0]      inst,
    output logic [op_width-1:0]        opcode,
    output logic [xlen-1:0]            alu_result,
    output logic [xlen-1:0]            src2
);

    // **********************************************************************
    // ex/mem pipeline register
    // **********************************************************************

    always_ff @(posedge clk) begin
        if (rst) begin
            valid      <= 1'b0;
            pc         <= '0;
            inst       <= '0;
            opcode     <= '0;
            alu_result <= '0;
            src2       <= '0;
        end else if (capture) begin
            // bubbles get captured too, valid drops low
            valid      <= valid_in;
            pc         <= pc_in;
            inst       <= inst_in;
            opcode     <= opcode_in;
            alu_result <= alu_result_in;
            src2       <= src2_in;
        end
        // no capture: downstream stalled, hold everything
    end

endmodule

`default_nettype wire

/* hw/mem_stage_pkg.sv */
`default_nettype none

package mem_stage_pkg;

    // datapath widths
    localparam int xlen       = 64;
    localparam int inst_width = 32;
    localparam int op_width   = 24;
    localparam int lanes      = 8;
    localparam int lane_bits  = 3;

    // **********************************************************************
    // opcodes handled by the memory stage
    // **********************************************************************

    // loads
    localparam logic [op_width-1:0] op_lb  = 24'd11;
    localparam logic [op_width-1:0] op_lh  = 24'd12;
    localparam logic [op_width-1:0] op_lw  = 24'd13;
    localparam logic [op_width-1:0] op_lbu = 24'd14;
    localparam logic [op_width-1:0] op_lhu = 24'd15;
    localparam logic [op_width-1:0] op_lwu = 24'd41;
    localparam logic [op_width-1:0] op_ld  = 24'd42;

    // stores
    localparam logic [op_width-1:0] op_sb = 24'd16;
    localparam logic [op_width-1:0] op_sh = 24'd17;
    localparam logic [op_width-1:0] op_sw = 24'd18;
    localparam logic [op_width-1:0] op_sd = 24'd43;

    // link and csr
    localparam logic [op_width-1:0] op_jal   = 24'h000300;
    localparam logic [op_width-1:0] op_jalr  = 24'd4;
    localparam logic [op_width-1:0] op_csrrw = 24'd49;
    localparam logic [op_width-1:0] op_csrrs = 24'd50;

    // everything else that writes the alu result to rd
    localparam int alu_wb_count = 38;
    localparam logic [op_width-1:0] alu_wb_ops [alu_wb_count] = '{
        24'h004000, 24'h005000, 24'h006000, 24'h007000, 24'h008000, 24'h009000,
        24'h010000, 24'h012000, 24'h013000, 24'h014000, 24'h015000, 24'h016000,
        24'h017000, 24'h018000, 24'h019000, 24'h01a000, 24'h01b000, 24'h01d000,
        24'h021000, 24'h022000, 24'h024000, 24'h025000, 24'h026000, 24'h027000,
        24'h028000, 24'h029000, 24'h000100, 24'h000200, 24'h000400, 24'h000800,
        24'h000c00, 24'd19, 24'd20, 24'd21, 24'd22, 24'd23, 24'd24, 24'd47
    };

    // write-back source select
    localparam logic [1:0] wb_alu  = 2'd0;
    localparam logic [1:0] wb_link = 2'd1;
    localparam logic [1:0] wb_load = 2'd2;
    localparam logic [1:0] wb_src2 = 2'd3;

    // one memory word, seen as bytes or as 32-bit halves
    typedef union packed {
        logic [lanes-1:0][7:0] bytes;
        logic [1:0][31:0]      halves;
    } mem_word_t;

    // returns 1 if op writes rd, src gets the value source
    function automatic logic wb_source_of(input logic [op_width-1:0] op,
                                          output logic [1:0] src);
        logic writes;
        writes = 1'b1;
        src    = wb_alu;
        case (op)
            op_jal, op_jalr:                             src = wb_link;
            op_lb, op_lh, op_lw, op_lbu, op_lhu, op_lwu, op_ld: src = wb_load;
            op_csrrw, op_csrrs:                          src = wb_src2;
            default: begin
                // table lookup for the alu class
                writes = 1'b0;
                for (int i = 0; i < alu_wb_count; i++) begin
                    if (op == alu_wb_ops[i]) begin
                        writes = 1'b1;
                    end
                end
            end
        endcase
        return writes;
    endfunction

endpackage

`default_nettype wire
